//--- all.f
hdl/cpu_pkg.sv
hdl/wb_if.sv
hdl/program_counter.sv
hdl/register_file.sv
hdl/cpu_control.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/wb_arbiter.sv
hdl/cpu_top.sv
testbench/cpu_tb.sv

//--- hdl/cpu_control.sv
// ======================================================================
// Core control.
// Multicycle FSM, instruction decode, ALU, compare flags and
// next-PC selection.
// ======================================================================
`timescale 1ns/1ps

module cpu_control (
    input  logic                  CLK,
    input  logic                  rst,
    output logic                  fetch_start,
    input  logic                  fetch_done,
    input  cpu_pkg::instr_u       instr,
    output logic                  mem_start,
    output logic                  mem_we,
    output cpu_pkg::word_t        mem_addr,
    output cpu_pkg::word_t        mem_wdata,
    input  logic                  mem_done,
    input  cpu_pkg::word_t        mem_rdata,
    input  cpu_pkg::word_t        pc,
    output logic                  pc_write,
    output logic                  is_branch,
    output logic                  zero,
    output logic                  negative,
    output cpu_pkg::word_t        new_pc,
    output cpu_pkg::branch_type_e branch_type,
    output logic [3:0]            ra,
    output logic [3:0]            rb,
    input  cpu_pkg::word_t        rdata_a,
    input  cpu_pkg::word_t        rdata_b,
    output logic                  we,
    output logic [3:0]            wa,
    output cpu_pkg::word_t        wdata,
    output logic                  halt
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALTED
    } state_t;

    state_t  state;
    logic    busy;                                // Unit request in flight.
    opcode_e op;
    logic    op_reg;                              // Register-register ALU op.
    logic    op_branch;                           // One of the four branches.
    logic    op_write;                            // Writes rd in writeback.
    word_t   imm_sext;                            // Sign-extended imm8.
    word_t   diff;                                // rs - rd, also SUB result.
    word_t   alu_out;
    word_t   result;                              // ALU result held for writeback.

    // Decode.
    assign op        = instr.r.op;
    assign op_reg    = op inside {ADD, SUB, AND, OR, XOR};
    assign op_branch = op inside {BEQ, BGE, BNE, BLE};
    assign op_write  = op_reg || op == ADDI || op == LDI || op == LD;
    assign imm_sext  = {{8{instr.i.imm8[7]}}, instr.i.imm8};

    assign ra = (op == ADDI) ? instr.r.rd : instr.r.rs; // ADDI adds to rd.
    assign rb = op_reg ? instr.r.rt : instr.r.rd;       // Store data and compare.

    // ALU.
    assign diff = rdata_a - rdata_b;

    always_comb begin
        case (op)
            ADD:     alu_out = rdata_a + rdata_b;
            SUB:     alu_out = diff;
            AND:     alu_out = rdata_a & rdata_b;
            OR:      alu_out = rdata_a | rdata_b;
            XOR:     alu_out = rdata_a ^ rdata_b;
            ADDI:    alu_out = rdata_a + imm_sext;
            default: alu_out = imm_sext;          // LDI.
        endcase
    end

    always_ff @(posedge CLK) begin
        if (state == S_EXEC) begin
            result <= alu_out;
        end
    end

    // FSM.
    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= S_FETCH;                     // First fetch right after reset.
            busy  <= 1'b0;
        end else begin
            if (fetch_start || mem_start) begin
                busy <= 1'b1;
            end else if (fetch_done || mem_done) begin
                busy <= 1'b0;
            end
            case (state)
                S_FETCH: begin
                    if (fetch_done) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (op == HALT) begin
                        state <= S_HALTED;
                    end else if (op == LD || op == ST) begin
                        state <= S_MEM;
                    end else if (op_write) begin
                        state <= S_WB;
                    end else begin
                        state <= S_FETCH;         // Branch, jump, unused opcode.
                    end
                end
                S_MEM: begin
                    if (mem_done) begin
                        state <= (op == LD) ? S_WB : S_FETCH;
                    end
                end
                S_WB:    state <= S_FETCH;
                default: state <= S_HALTED;       // Stays halted.
            endcase
        end
    end

    // Unit requests, one pulse per state entry.
    assign fetch_start = (state == S_FETCH) && !busy;
    assign mem_start   = (state == S_MEM) && !busy;
    assign mem_we      = (op == ST);
    assign mem_addr    = rdata_a;                 // Address from rs.
    assign mem_wdata   = rdata_b;                 // Store data from rd.

    // Next PC: pc+1 at end of fetch, target in execute.
    assign zero        = (diff == '0);
    assign negative    = diff[15];
    assign branch_type = branch_type_e'(instr.r.op[1:0]);
    assign is_branch   = (state == S_EXEC) && op_branch;
    assign pc_write    = (state == S_FETCH && fetch_done) ||
                         (state == S_EXEC && (op_branch || op == JMP));

    always_comb begin
        if (state != S_EXEC) begin
            new_pc = pc + 16'd1;
        end else if (op == JMP) begin
            new_pc = {8'h00, instr.i.imm8};
        end else begin
            new_pc = pc + {{12{instr.r.rt[3]}}, instr.r.rt}; // pc already past branch.
        end
    end

    // Writeback.
    assign we    = (state == S_WB);
    assign wa    = instr.r.rd;
    assign wdata = (op == LD) ? mem_rdata : result;

    assign halt = (state == S_HALTED);

    // Fetch and data transfers must never overlap, so each unit answers
    // only while the FSM waits for it.
    a_done_state: assert property (@(posedge CLK) disable iff (rst)
        !(fetch_done && state != S_FETCH) && !(mem_done && state != S_MEM))
        else $error("unit finished a transfer outside its wait state");

endmodule

//--- hdl/cpu_pkg.sv
// ======================================================================
// Shared types for the 16-bit multicycle core.
// Holds the data word, opcodes, branch selectors and the instruction
// word with its register and immediate views.
// ======================================================================
package cpu_pkg;

    typedef logic [15:0] word_t;                  // Data and word address.

    // Branches sit at 10xx so the low bits select the condition.
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        ADDI = 4'h5,
        LDI  = 4'h6,
        LD   = 4'h7,
        BEQ  = 4'h8,
        BGE  = 4'h9,
        BNE  = 4'hA,
        BLE  = 4'hB,
        ST   = 4'hC,
        JMP  = 4'hD,
        HALT = 4'hE
    } opcode_e;

    typedef enum logic [1:0] {
        BR_EQ = 2'b00,                            // Taken if zero.
        BR_GE = 2'b01,                            // Taken if not negative.
        BR_NE = 2'b10,                            // Taken if not zero.
        BR_LE = 2'b11                             // Taken if negative or zero.
    } branch_type_e;

    typedef struct packed {
        opcode_e    op;
        logic [3:0] rd;                           // Destination, or compare operand.
        logic [3:0] rs;                           // First source, or address.
        logic [3:0] rt;                           // Second source, or branch offset.
    } instr_r_t;

    typedef struct packed {
        opcode_e    op;
        logic [3:0] rd;
        logic [7:0] imm8;                         // Immediate or jump target.
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

//--- hdl/cpu_top.sv
// ======================================================================
// Core top level.
// Control, PC, register file, fetch and data masters, arbiter.
// One Wishbone classic master port and halt.
// ======================================================================
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::word_t reset_pc = 16'h0000
) (
    input  logic        CLK,
    input  logic        rst,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [15:0] wb_adr,
    output logic [15:0] wb_dat_w,
    input  logic [15:0] wb_dat_r,
    input  logic        wb_ack,
    output logic        halt
);
    import cpu_pkg::*;

    wb_if fetch_bus ();
    wb_if lsu_bus ();
    wb_if mem_bus ();

    logic         fetch_start, fetch_done;
    instr_u       instr;
    logic         mem_start, mem_we, mem_done;
    word_t        mem_addr, mem_wdata, mem_rdata;
    word_t        pc, new_pc;
    logic         pc_write, is_branch, zero, negative;
    branch_type_e branch_type;
    logic [3:0]   ra, rb, wa;
    word_t        rdata_a, rdata_b, wdata;
    logic         we;

    assign wb_cyc      = mem_bus.cyc;
    assign wb_stb      = mem_bus.stb;
    assign wb_we       = mem_bus.we;
    assign wb_adr      = mem_bus.adr;
    assign wb_dat_w    = mem_bus.dat_w;
    assign mem_bus.dat_r = wb_dat_r;
    assign mem_bus.ack   = wb_ack;

    cpu_control u_ctrl (
        .CLK(CLK), .rst(rst),
        .fetch_start(fetch_start), .fetch_done(fetch_done), .instr(instr),
        .mem_start(mem_start), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_done(mem_done), .mem_rdata(mem_rdata),
        .pc(pc), .pc_write(pc_write), .is_branch(is_branch), .zero(zero),
        .negative(negative), .new_pc(new_pc), .branch_type(branch_type),
        .ra(ra), .rb(rb), .rdata_a(rdata_a), .rdata_b(rdata_b),
        .we(we), .wa(wa), .wdata(wdata), .halt(halt)
    );

    program_counter #(.reset_pc(reset_pc)) u_pc (
        .CLK(CLK), .rst(rst), .pc_write(pc_write), .is_branch(is_branch),
        .zero(zero), .negative(negative), .new_pc(new_pc),
        .branch_type(branch_type), .pc(pc)
    );

    register_file u_rf (
        .CLK(CLK), .ra(ra), .rb(rb), .rdata_a(rdata_a), .rdata_b(rdata_b),
        .we(we), .wa(wa), .wdata(wdata)
    );

    fetch_unit u_fetch (
        .CLK(CLK), .rst(rst), .start(fetch_start), .pc(pc),
        .done(fetch_done), .instr(instr), .bus(fetch_bus.master)
    );

    load_store_unit u_lsu (
        .CLK(CLK), .rst(rst), .start(mem_start), .we(mem_we),
        .addr(mem_addr), .wdata(mem_wdata), .done(mem_done),
        .rdata(mem_rdata), .bus(lsu_bus.master)
    );

    wb_arbiter u_arb (
        .CLK(CLK), .rst(rst),
        .m0(lsu_bus.slave), .m1(fetch_bus.slave), .s(mem_bus.master)
    );

endmodule

//--- hdl/fetch_unit.sv
// ======================================================================
// Instruction fetch.
// Wishbone master read at pc, instruction register, done pulse.
// ======================================================================
`timescale 1ns/1ps

module fetch_unit (
    input  logic            CLK,
    input  logic            rst,
    input  logic            start,
    input  cpu_pkg::word_t  pc,
    output logic            done,
    output cpu_pkg::instr_u instr,
    wb_if.master            bus
);

    assign bus.we    = 1'b0;                      // Read only.
    assign bus.dat_w = 16'h0000;

    always_ff @(posedge CLK) begin
        if (rst) begin
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= bus.cyc && bus.ack;           // One cycle after ack.
            if (start) begin
                bus.cyc <= 1'b1;
                bus.stb <= 1'b1;
            end else if (bus.ack) begin
                bus.cyc <= 1'b0;
                bus.stb <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            bus.adr <= pc;                        // Held until ack.
        end
        if (bus.cyc && bus.ack) begin
            instr <= bus.dat_r;
        end
    end

    // A new fetch only begins on an idle bus.
    a_start_idle: assert property (@(posedge CLK) disable iff (rst)
        start |-> !bus.cyc)
        else $error("fetch started during an open bus cycle");

endmodule

//--- hdl/load_store_unit.sv
// ======================================================================
// Data load and store.
// Wishbone master read or write, load data register, done pulse.
// ======================================================================
`timescale 1ns/1ps

module load_store_unit (
    input  logic           CLK,
    input  logic           rst,
    input  logic           start,
    input  logic           we,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    output logic           done,
    output cpu_pkg::word_t rdata,
    wb_if.master           bus
);

    always_ff @(posedge CLK) begin
        if (rst) begin
            bus.cyc <= 1'b0;
            bus.stb <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= bus.cyc && bus.ack;
            if (start) begin
                bus.cyc <= 1'b1;
                bus.stb <= 1'b1;
            end else if (bus.ack) begin
                bus.cyc <= 1'b0;                  // Drop on the clock after ack.
                bus.stb <= 1'b0;
            end
        end
    end

    // Request attributes captured once per transfer.
    always_ff @(posedge CLK) begin
        if (start) begin
            bus.we    <= we;
            bus.adr   <= addr;
            bus.dat_w <= wdata;
        end
        if (bus.cyc && bus.ack && !bus.we) begin
            rdata <= bus.dat_r;                   // Load data.
        end
    end

    a_req_stable: assert property (@(posedge CLK) disable iff (rst)
        bus.stb && !bus.ack |=> $stable(bus.adr) && $stable(bus.we))
        else $error("data request changed while waiting for ack");

endmodule

//--- hdl/program_counter.sv
// ======================================================================
// Program counter.
// Reset vector, plain update and branch condition check on the
// compare flags.
// ======================================================================
`timescale 1ns/1ps

module program_counter #(
    parameter cpu_pkg::word_t reset_pc = 16'h0000
) (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  pc_write,
    input  logic                  is_branch,
    input  logic                  zero,
    input  logic                  negative,
    input  cpu_pkg::word_t        new_pc,
    input  cpu_pkg::branch_type_e branch_type,
    output cpu_pkg::word_t        pc
);
    import cpu_pkg::*;

    logic taken;                                  // Branch condition holds.

    always_comb begin
        case (branch_type)
            BR_EQ:   taken = zero;
            BR_GE:   taken = !negative;
            BR_NE:   taken = !zero;
            default: taken = negative || zero;    // BR_LE.
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (pc_write && (!is_branch || taken)) begin
            pc <= new_pc;                         // Untaken branch keeps pc.
        end
    end

endmodule

//--- hdl/register_file.sv
// ======================================================================
// Register file, sixteen 16-bit registers.
// Two asynchronous read ports, one synchronous write port.
// ======================================================================
`timescale 1ns/1ps

module register_file (
    input  logic           CLK,
    input  logic [3:0]     ra,
    input  logic [3:0]     rb,
    output cpu_pkg::word_t rdata_a,
    output cpu_pkg::word_t rdata_b,
    input  logic           we,
    input  logic [3:0]     wa,
    input  cpu_pkg::word_t wdata
);
    import cpu_pkg::*;

    word_t regs [16];                             // r0 is an ordinary register.

    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];

    always_ff @(posedge CLK) begin
        if (we) begin
            regs[wa] <= wdata;
        end
    end

endmodule

//--- hdl/wb_arbiter.sv
// ======================================================================
// Two-master Wishbone arbiter.
// m0 has priority, grant locked until the owner drops cyc.
// Combinational routing, registered grant.
// ======================================================================
`timescale 1ns/1ps

module wb_arbiter (
    input logic  CLK,
    input logic  rst,
    wb_if.slave  m0,                              // Data side, high priority.
    wb_if.slave  m1,                              // Fetch side.
    wb_if.master s
);

    logic lock;                                   // A cycle was granted last clock.
    logic owner;                                  // Granted master, 1 is m1.
    logic held;                                   // Owner still in its cycle.
    logic sel;                                    // Master routed this cycle.

    assign held = lock && (owner ? m1.cyc : m0.cyc);
    assign sel  = held ? owner : !m0.cyc;         // Free bus goes to m0 first.

    assign s.cyc   = sel ? m1.cyc : m0.cyc;
    assign s.stb   = sel ? m1.stb : m0.stb;
    assign s.we    = sel ? m1.we : m0.we;
    assign s.adr   = sel ? m1.adr : m0.adr;
    assign s.dat_w = sel ? m1.dat_w : m0.dat_w;

    // Other master sees no ack and waits.
    assign m0.ack   = s.ack && s.cyc && !sel;
    assign m1.ack   = s.ack && s.cyc && sel;
    assign m0.dat_r = sel ? 16'h0000 : s.dat_r;
    assign m1.dat_r = sel ? s.dat_r : 16'h0000;

    always_ff @(posedge CLK) begin
        if (rst) begin
            lock  <= 1'b0;
            owner <= 1'b0;
        end else begin
            lock  <= s.cyc;
            owner <= sel;
        end
    end

    // An open cycle keeps its grant, so ack cannot move to the other master.
    a_grant_held: assert property (@(posedge CLK) disable iff (rst)
        s.cyc && !s.ack |=> $stable(sel))
        else $error("grant moved during an open bus cycle");

endmodule

//--- hdl/wb_if.sv
// ======================================================================
// Wishbone classic bus, 16-bit data and word address.
// Master and slave modports.
// ======================================================================
`timescale 1ns/1ps

interface wb_if;

    logic        cyc;                             // Bus cycle in progress.
    logic        stb;                             // Transfer strobe.
    logic        we;                              // Write enable.
    logic [15:0] adr;                             // Word address.
    logic [15:0] dat_w;                           // Write data.
    logic [15:0] dat_r;                           // Read data, valid with ack.
    logic        ack;                             // Transfer done.

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

//--- run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cpu_tb \
    -Mdir obj_dir -o cpu_tb_sim \
    && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- testbench/cpu_tb.sv
// ======================================================================
// Testbench for the 16-bit multicycle core.
// Clock, reset, random program generator, Wishbone memory slave with
// random wait states, ISA reference model and result checks.
// ======================================================================
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 16;
    localparam int    QUIET_CYCLES = 50;              // Bus must stay idle after halt.
    localparam int    SEED         = 90195;
    localparam int    BODY_LEN     = 48;              // Generated instructions.
    localparam int    PROG_WORDS   = BODY_LEN + 8;    // Body plus a pad of HALT.
    localparam int    N_MODES      = 4;
    localparam int    N_TESTS      = 2 * N_MODES;     // Each program at delay 0 and random.
    localparam int    WATCHDOG_NS  = N_TESTS * CLK_PERIOD *
                                     (PROG_WORDS * 8 * 4 + RESET_CYCLES + QUIET_CYCLES);
    localparam int    BASE         = 16;              // Program load address and reset vector.
    localparam word_t RESET_PC     = 16'(BASE);

    logic        CLK;
    logic        rst      = 1'b1;
    logic        wb_cyc, wb_stb, wb_we, halt;
    logic [15:0] wb_adr, wb_dat_w;
    logic [15:0] wb_dat_r = 16'h0000;
    logic        wb_ack   = 1'b0;

    word_t       image [256];                         // Memory contents loaded in reset.
    word_t       mem [256];                           // Memory seen by the DUT.
    word_t       model_mem [256];                     // Reference memory after the run.
    logic [32:0] bus_log [$];                         // {we, adr, write data} per transfer.
    logic [32:0] exp_log [$];
    logic [32:0] req_attr;                            // Request seen at first strobe.
    logic        pending;
    int          wait_left;
    int          hold_changes;
    int          max_delay;                           // Ack wait states, 0 to this value.
    int          error_count  = 0;
    int          tests_failed = 0;
    string       cur_test     = "";

    cpu_top #(.reset_pc(RESET_PC)) DUT (
        .CLK(CLK), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack), .halt(halt)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Memory slave, registered ack after 0 to max_delay wait states.
    always @(posedge CLK) begin : mem_slave
        int left;
        if (rst) begin
            wb_ack       <= 1'b0;
            pending      <= 1'b0;
            hold_changes <= 0;
            bus_log.delete();
            for (int a = 0; a < 256; a++) begin
                mem[a] = image[a];                    // Reload program and data.
            end
        end else if (wb_ack) begin
            wb_ack  <= 1'b0;                          // Transfer ends on this edge.
            pending <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!pending) begin
                left = (max_delay == 0) ? 0 : int'($urandom % 32'(max_delay + 1));
                req_attr <= {wb_we, wb_adr, wb_dat_w};
                pending  <= 1'b1;
            end else begin
                left = wait_left;
                if (req_attr != {wb_we, wb_adr, wb_dat_w}) begin
                    $display("%s: request changed while waiting for ack", cur_test);
                    hold_changes <= hold_changes + 1;
                end
            end
            if (left == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[wb_adr[7:0]];
                if (wb_we) begin
                    mem[wb_adr[7:0]] = wb_dat_w;
                end
                bus_log.push_back({wb_we, wb_adr, wb_we ? wb_dat_w : 16'h0000});
            end else begin
                wait_left <= left - 1;
            end
        end
    end

    function automatic logic [3:0] rand_nibble();
        return 4'($urandom % 16);
    endfunction

    function automatic logic [7:0] rand_byte();
        return 8'($urandom % 256);
    endfunction

    function automatic logic [3:0] rand_dest();
        return 4'($urandom % 15);                     // r15 is kept as the data address.
    endfunction

    // Kinds: 0-3 ALU, 4 ADDI, 5 LDI, 6 ST, 7 LD, 8 branch, 9 JMP.
    task automatic make_program(input int kinds);
        int         idx;
        int         kind;
        logic [3:0] rd;
        logic [3:0] rs;
        for (int a = 0; a < 256; a++) begin
            image[a] = {8'(a) ^ 8'hC3, 8'(255 - a)};
        end
        for (idx = 0; idx < 15; idx++) begin
            image[BASE + idx] = {LDI, 4'(idx), rand_byte()};
        end
        image[BASE + 15] = {LDI, 4'hF, 5'b10000, 3'($urandom % 8)};
        idx = 16;
        while (idx < BODY_LEN) begin
            kind = int'($urandom % 32'(kinds));
            case (kind)
                4: image[BASE + idx] = {ADDI, rand_dest(), rand_byte()};
                5: image[BASE + idx] = {LDI, rand_dest(), rand_byte()};
                6, 7: begin
                    if (idx + 2 <= BODY_LEN) begin
                        // Few distinct addresses, so loads often hit earlier stores.
                        image[BASE + idx] = {LDI, 4'hF, 5'b10000, 3'($urandom % 8)};
                        idx++;
                        if (kind == 6) begin
                            image[BASE + idx] = {ST, rand_nibble(), 4'hF, 4'h0};
                        end else begin
                            image[BASE + idx] = {LD, rand_dest(), 4'hF, 4'h0};
                        end
                    end else begin
                        image[BASE + idx] = {ADDI, rand_dest(), rand_byte()};
                    end
                end
                8: begin
                    rs = rand_nibble();
                    rd = ($urandom % 2 == 0) ? rs : rand_nibble();  // Equal operands half the time.
                    image[BASE + idx] = {2'b10, 2'($urandom % 4), rd, rs,
                                         4'(1 + $urandom % 7)};
                end
                9: image[BASE + idx] = {JMP, 4'h0, 8'(BASE + idx + 2 + int'($urandom % 7))};
                default: image[BASE + idx] = {opcode_e'(4'($urandom % 5)), rand_dest(),
                                              rand_nibble(), rand_nibble()};
            endcase
            idx++;
        end
        for (idx = BODY_LEN; idx < PROG_WORDS; idx++) begin
            image[BASE + idx] = {HALT, 12'h000};      // Landing pad for forward jumps.
        end
    endtask

    // ISA interpreter: expected bus transfers and final memory.
    task automatic run_model();
        word_t      r [16];
        word_t      pc;
        word_t      ins;
        word_t      diff;
        logic [3:0] rd, rs, rt;
        logic       taken;
        logic       stop;
        int         steps;
        exp_log.delete();
        model_mem = image;
        pc        = RESET_PC;
        stop      = 1'b0;
        steps     = 0;
        while (!stop && steps < PROG_WORDS) begin
            ins = model_mem[pc[7:0]];
            rd  = ins[11:8];
            rs  = ins[7:4];
            rt  = ins[3:0];
            exp_log.push_back({1'b0, pc, 16'h0000});  // Instruction fetch.
            pc = pc + 16'd1;
            steps++;
            case (opcode_e'(ins[15:12]))
                ADD:  r[rd] = r[rs] + r[rt];
                SUB:  r[rd] = r[rs] - r[rt];
                AND:  r[rd] = r[rs] & r[rt];
                OR:   r[rd] = r[rs] | r[rt];
                XOR:  r[rd] = r[rs] ^ r[rt];
                ADDI: r[rd] = r[rd] + {{8{ins[7]}}, ins[7:0]};
                LDI:  r[rd] = {{8{ins[7]}}, ins[7:0]};
                LD: begin
                    exp_log.push_back({1'b0, r[rs], 16'h0000});
                    r[rd] = model_mem[r[rs][7:0]];
                end
                ST: begin
                    exp_log.push_back({1'b1, r[rs], r[rd]});
                    model_mem[r[rs][7:0]] = r[rd];
                end
                BEQ, BGE, BNE, BLE: begin
                    diff = r[rs] - r[rd];
                    case (ins[13:12])
                        2'b00:   taken = (diff == 16'h0000);
                        2'b01:   taken = !diff[15];
                        2'b10:   taken = (diff != 16'h0000);
                        default: taken = diff[15] || (diff == 16'h0000);
                    endcase
                    if (taken) begin
                        pc = pc + {{12{rt[3]}}, rt};  // Relative to the next instruction.
                    end
                end
                JMP:  pc = {8'h00, ins[7:0]};
                HALT: stop = 1'b1;
                default: ;
            endcase
        end
    endtask

    task automatic run_test(input string name, input int delay);
        int errs_before;
        int mark;
        int n;
        errs_before = error_count;
        cur_test    = name;
        max_delay   = delay;
        @(posedge CLK);
        rst <= 1'b1;
        repeat (RESET_CYCLES - 1) begin
            @(posedge CLK);
            @(negedge CLK);
            check({name, " cyc in reset"}, 64'(0), 64'(wb_cyc));
            check({name, " stb in reset"}, 64'(0), 64'(wb_stb));
            check({name, " halt in reset"}, 64'(0), 64'(halt));
        end
        @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        check({name, " cyc after reset"}, 64'(0), 64'(wb_cyc));
        check({name, " halt after reset"}, 64'(0), 64'(halt));
        @(negedge CLK);
        check({name, " first fetch cyc"}, 64'(1), 64'(wb_cyc));
        check({name, " first fetch stb"}, 64'(1), 64'(wb_stb));
        check({name, " first fetch adr"}, 64'(RESET_PC), 64'(wb_adr));
        while (halt !== 1'b1) begin
            @(negedge CLK);                           // Watchdog ends a hang.
        end
        repeat (QUIET_CYCLES) begin
            @(negedge CLK);
            check({name, " cyc after halt"}, 64'(0), 64'(wb_cyc));
            check({name, " stb after halt"}, 64'(0), 64'(wb_stb));
            check({name, " halt held"}, 64'(1), 64'(halt));
        end
        check({name, " transfer count"}, 64'(exp_log.size()), 64'(bus_log.size()));
        n    = (exp_log.size() < bus_log.size()) ? exp_log.size() : bus_log.size();
        mark = error_count;
        for (int i = 0; i < n; i++) begin
            check($sformatf("%s transfer %0d", name, i), 64'(exp_log[i]), 64'(bus_log[i]));
            if (error_count != mark) begin
                break;                                // Later entries follow from this one.
            end
        end
        for (int a = 128; a < 256; a++) begin
            check($sformatf("%s mem[%0d]", name, a), 64'(model_mem[a]), 64'(mem[a]));
        end
        check({name, " request changes"}, 64'(0), 64'(hold_changes));
        if (error_count != errs_before) begin
            tests_failed++;
        end
        $display("test %s done, %0d errors", name, error_count - errs_before);
    endtask

    function automatic string mode_name(input int m);
        case (m)
            0:       return "alu_imm";
            1:       return "load_store";
            2:       return "branch";
            default: return "jump_halt";
        endcase
    endfunction

    initial begin : main
        void'($urandom(SEED));
        max_delay = 0;
        for (int m = 0; m < N_MODES; m++) begin
            make_program(7 + m);                      // Each mode adds one kind of instruction.
            run_model();
            run_test({mode_name(m), "/d0"}, 0);
            run_test({mode_name(m), "/d3"}, 3);       // Same program with random wait states.
        end
        $display("%0d tests, %0d failed, %0d errors", N_TESTS, tests_failed, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the core did not finish all tests within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule
